/* project.f */
+incdir+include
hdl/ntm_mod_pkg.sv
hdl/ntm_scalar_mod.sv
hdl/ntm_vector_mod.sv
hdl/ntm_mod_top.sv
testbench/ntm_mod_tb.sv

/* Makefile */
# Verilator build for the vector modulo unit

VERILATOR    ?= verilator
TOP          := ntm_mod_tb
RTL_TOP      := ntm_mod_top
FILELIST     := project.f
OBJ_DIR      := obj_dir
COMMON_FLAGS := --timing --assert -Wno-fatal
LINT_FLAGS   := --lint-only -Wall
BUILD_FLAGS  := --binary -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(COMMON_FLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(COMMON_FLAGS) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/ntm_mod_tb.sv */
// Vector modulo testbench

`timescale 1ns/1ps
`default_nettype none

`include "ntm_mod_macros.svh"

module ntm_mod_tb;

  //////////////////////////////////////////////////////////////////////
  // Limits
  //////////////////////////////////////////////////////////////////////

  // DATA_IN_ENABLE sampling edge to DATA_OUT_ENABLE edge
  localparam int unsigned latency_cycles = 19;
  // Twice the run of about 48 elements at 20 cycles
  localparam int unsigned timeout_cycles = 2000;

  //////////////////////////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////////////////////////

  logic                         CLK;
  logic                         RST;
  logic                         start;
  logic [`NTM_CONTROL_SIZE-1:0] size_in;
  logic                         data_in_enable;
  ntm_mod_pkg::mod_operand_t    operand_in;
  logic                         ready;
  logic                         data_out_enable;
  logic [`NTM_DATA_SIZE-1:0]    data_out;

  // Pairs for the vector under test
  ntm_mod_pkg::mod_operand_t    vector_ops [0:15];
  integer                       seed = 93;
  int unsigned                  cycle_count = 0;

  ntm_mod_top uut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start),
    .SIZE_IN         (size_in),
    .DATA_IN_ENABLE  (data_in_enable),
    .OPERAND_IN      (operand_in),
    .READY           (ready),
    .DATA_OUT_ENABLE (data_out_enable),
    .DATA_OUT        (data_out)
  );

  // 4 ns period
  always #2 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Failure handling and compares
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  // Watchdog on total run length
  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      stop_on_error($sformatf("run did not finish within %0d cycles", timeout_cycles));
    end
  end

  task automatic check_data(input string name, input logic [`NTM_DATA_SIZE-1:0] expected,
                            input logic [`NTM_DATA_SIZE-1:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_operand(input string name, input ntm_mod_pkg::mod_operand_t expected,
                               input ntm_mod_pkg::mod_operand_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Zero modulus returns the dividend unchanged
  function automatic logic [`NTM_DATA_SIZE-1:0] model_remainder(
      input ntm_mod_pkg::mod_operand_t op);
    if (op.modulus == '0) begin
      return op.data;
    end
    return op.data % op.modulus;
  endfunction

  function automatic ntm_mod_pkg::mod_operand_t make_pair(
      input logic [`NTM_DATA_SIZE-1:0] data, input logic [`NTM_DATA_SIZE-1:0] modulus);
    ntm_mod_pkg::mod_operand_t op;
    op.data    = data;
    op.modulus = modulus;
    return op;
  endfunction

  // All stimulus tasks begin and end 0.5 ns after a rising edge
  task automatic start_vector(input logic [`NTM_CONTROL_SIZE-1:0] length);
    start   = 1'b1;
    size_in = length;
    @(posedge CLK);
    #0.5;
    start   = 1'b0;
  endtask

  task automatic send_element(input string name, input ntm_mod_pkg::mod_operand_t op,
                              input logic is_last);
    int unsigned cycles;
    logic        seen;
    cycles         = 0;
    seen           = 1'b0;
    data_in_enable = 1'b1;
    operand_in     = op;
    @(posedge CLK);
    #0.5;
    data_in_enable = 1'b0;
    operand_in     = '0;
    // Pair held for the scalar run
    check_operand({name, " latched pair"}, op, uut.vector_mod_unit.scalar_operand);
    while (!seen && cycles < latency_cycles) begin
      @(posedge CLK);
      #0.5;
      cycles++;
      if (data_out_enable) begin
        seen = 1'b1;
      end else begin
        check_flag({name, " early ready"}, 1'b0, ready);
      end
    end
    if (!seen) begin
      stop_on_error($sformatf("no DATA_OUT_ENABLE within %0d cycles for %s",
                              latency_cycles, name));
    end
    if (cycles != latency_cycles) begin
      stop_on_error($sformatf("mismatch %s latency expected %0d actual %0d",
                              name, latency_cycles, cycles));
    end
    check_data({name, " remainder"}, model_remainder(op), data_out);
    check_flag({name, " ready"}, is_last, ready);
  endtask

  task automatic run_vector(input string name,
                            input logic [`NTM_CONTROL_SIZE-1:0] length);
    start_vector(length);
    for (int unsigned i = 0; i < length; i++) begin
      send_element($sformatf("%s element %0d", name, i), vector_ops[i], i == length - 1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    check_flag("reset ready", 1'b0, ready);
    check_flag("reset data_out_enable", 1'b0, data_out_enable);
    check_data("reset data_out", '0, data_out);
  endtask

  task automatic test_single_element();
    vector_ops[0] = make_pair(16'd100, 16'd7);
    run_vector("single 100 mod 7", 1);
    vector_ops[0] = make_pair(16'd7, 16'd7);
    run_vector("single 7 mod 7", 1);
    vector_ops[0] = make_pair(16'd3, 16'd9);
    run_vector("single 3 mod 9", 1);
  endtask

  task automatic test_multi_element();
    vector_ops[0] = make_pair(16'd1000, 16'd33);
    vector_ops[1] = make_pair(16'd65000, 16'd255);
    vector_ops[2] = make_pair(16'd4096, 16'd64);
    vector_ops[3] = make_pair(16'd12345, 16'd678);
    vector_ops[4] = make_pair(16'd9, 16'd2);
    vector_ops[5] = make_pair(16'h8001, 16'h4000);
    vector_ops[6] = make_pair(16'd31415, 16'd27);
    vector_ops[7] = make_pair(16'd500, 16'd499);
    run_vector("multi", 8);
  endtask

  task automatic test_edge_operands();
    vector_ops[0] = make_pair(16'd1234, 16'd0);
    vector_ops[1] = make_pair(16'hBEEF, 16'd1);
    vector_ops[2] = make_pair(16'hFFFF, 16'd255);
    vector_ops[3] = make_pair(16'hFFFF, 16'd0);
    vector_ops[4] = make_pair(16'd25, 16'd1000);
    vector_ops[5] = make_pair(16'hFFFF, 16'hFFFF);
    run_vector("edge", 6);
  endtask

  task automatic test_random_vectors();
    logic [`NTM_DATA_SIZE-1:0] data;
    logic [`NTM_DATA_SIZE-1:0] modulus;
    for (int v = 0; v < 3; v++) begin
      for (int i = 0; i < 10; i++) begin
        data    = `NTM_DATA_SIZE'($random(seed));
        // Vary divisor magnitude across the vector
        modulus = `NTM_DATA_SIZE'($random(seed));
        modulus = modulus >> i;
        if (modulus == '0) begin
          modulus = 16'd1;
        end
        vector_ops[i] = make_pair(data, modulus);
      end
      run_vector($sformatf("random vector %0d", v), 10);
    end
  endtask

  task automatic test_ignored_strobes();
    // Strobe while idle
    data_in_enable = 1'b1;
    operand_in     = make_pair(16'd77, 16'd5);
    @(posedge CLK);
    #0.5;
    data_in_enable = 1'b0;
    operand_in     = '0;
    repeat (25) begin
      @(posedge CLK);
      #0.5;
      check_flag("idle strobe data_out_enable", 1'b0, data_out_enable);
      check_flag("idle strobe ready", 1'b0, ready);
    end
    // Empty vector
    start_vector('0);
    check_flag("zero length ready early", 1'b0, ready);
    @(posedge CLK);
    #0.5;
    check_flag("zero length ready", 1'b1, ready);
    check_flag("zero length data_out_enable", 1'b0, data_out_enable);
    @(posedge CLK);
    #0.5;
    check_flag("zero length ready pulse", 1'b0, ready);
    // Controller back in service
    vector_ops[0] = make_pair(16'd50, 16'd6);
    run_vector("after zero length", 1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK            = 1'b0;
    RST            = 1'b1;
    start          = 1'b0;
    size_in        = '0;
    data_in_enable = 1'b0;
    operand_in     = '0;
    repeat (8) @(posedge CLK);
    #0.5;
    RST = 1'b0;

    test_reset_state();
    test_single_element();
    test_multi_element();
    test_edge_operands();
    test_random_vectors();
    test_ignored_strobes();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/ntm_mod_top.sv */
// Vector modulo subsystem top

`timescale 1ns/1ps
`default_nettype none

`include "ntm_mod_macros.svh"

module ntm_mod_top (
  input  wire logic                         CLK,
  input  wire logic                         RST,
  input  wire logic                         START,
  input  wire logic [`NTM_CONTROL_SIZE-1:0] SIZE_IN,
  input  wire logic                         DATA_IN_ENABLE,
  input  wire ntm_mod_pkg::mod_operand_t    OPERAND_IN,
  output logic                              READY,
  output logic                              DATA_OUT_ENABLE,
  output logic [`NTM_DATA_SIZE-1:0]         DATA_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Vector controller
  //////////////////////////////////////////////////////////////////////

  // Subsystem boundary toward the peripheral
  ntm_vector_mod vector_mod_unit (
    // Global
    .CLK             (CLK),
    .RST             (RST),

    // Control
    .START           (START),
    .SIZE_IN         (SIZE_IN),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),

    // Data
    .OPERAND_IN      (OPERAND_IN),
    .DATA_OUT        (DATA_OUT)
  );

endmodule

`default_nettype wire

/* hdl/ntm_vector_mod.sv */
// Vector modulo element controller

`timescale 1ns/1ps
`default_nettype none

`include "ntm_mod_macros.svh"

module ntm_vector_mod (
  input  wire logic                       CLK,
  input  wire logic                       RST,
  input  wire logic                       START,
  input  wire logic [`NTM_CONTROL_SIZE-1:0] SIZE_IN,
  input  wire logic                       DATA_IN_ENABLE,
  input  wire ntm_mod_pkg::mod_operand_t  OPERAND_IN,
  output logic                            READY,
  output logic                            DATA_OUT_ENABLE,
  output logic [`NTM_DATA_SIZE-1:0]       DATA_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  ntm_mod_pkg::vector_state_t    state;

  // Vector length and completed results
  logic [`NTM_CONTROL_SIZE-1:0]  length;
  logic [`NTM_CONTROL_SIZE-1:0]  element_index;
  logic                          last_element;

  // Scalar unit handshake
  logic                          scalar_start;
  ntm_mod_pkg::mod_operand_t     scalar_operand;
  logic                          scalar_ready;
  logic [`NTM_DATA_SIZE-1:0]     scalar_remainder;

  // Result in flight is the final one
  assign last_element = (element_index + 1'b1) == length;

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ntm_mod_pkg::starter_state;
      length          <= '0;
      element_index   <= '0;
      scalar_start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // Pulses default low
      scalar_start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      case (state)
        ntm_mod_pkg::starter_state: begin
          // Idle, strobes ignored here
          if (START) begin
            length        <= SIZE_IN;
            element_index <= '0;
            state         <= ntm_mod_pkg::input_state;
          end
        end
        ntm_mod_pkg::input_state: begin
          if (length == '0) begin
            // Empty vector ends at once
            READY <= 1'b1;
            state <= ntm_mod_pkg::starter_state;
          end else if (DATA_IN_ENABLE) begin
            // Kick the scalar unit for every element
            scalar_start <= 1'b1;
            state        <= ntm_mod_pkg::ender_state;
          end
        end
        ntm_mod_pkg::ender_state: begin
          if (scalar_ready) begin
            DATA_OUT        <= scalar_remainder;
            DATA_OUT_ENABLE <= 1'b1;
            if (last_element) begin
              READY <= 1'b1;
              state <= ntm_mod_pkg::starter_state;
            end else begin
              element_index <= element_index + 1'b1;
              state         <= ntm_mod_pkg::input_state;
            end
          end
        end
        default: begin
          state <= ntm_mod_pkg::starter_state;
        end
      endcase
    end
  end

  // Operand stays put for the whole scalar run
  always_ff @(posedge CLK) begin
    if (state == ntm_mod_pkg::input_state && length != '0 && DATA_IN_ENABLE) begin
      scalar_operand <= OPERAND_IN;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scalar unit
  //////////////////////////////////////////////////////////////////////

  ntm_scalar_mod scalar_mod_unit (
    .CLK       (CLK),
    .RST       (RST),
    .start     (scalar_start),
    .operand   (scalar_operand),
    .ready     (scalar_ready),
    .remainder (scalar_remainder)
  );

  // Every output word traces back to a scalar result
  a_out_after_scalar : assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> $past(scalar_ready))
    else $error("DATA_OUT_ENABLE without scalar result");

  // End of a non-empty vector carries its last result
  a_ready_with_out : assert property (@(posedge CLK) disable iff (RST)
    (READY && length != '0) |-> DATA_OUT_ENABLE)
    else $error("READY without last DATA_OUT_ENABLE");

endmodule

`default_nettype wire

/* hdl/ntm_scalar_mod.sv */
// Scalar restoring modulo unit

`timescale 1ns/1ps
`default_nettype none

`include "ntm_mod_macros.svh"

module ntm_scalar_mod (
  input  wire logic                      CLK,
  input  wire logic                      RST,
  input  wire logic                      start,
  input  wire ntm_mod_pkg::mod_operand_t operand,
  output logic                           ready,
  output logic [`NTM_DATA_SIZE-1:0]      remainder
);

  //////////////////////////////////////////////////////////////////////
  // Step counter sizing
  //////////////////////////////////////////////////////////////////////

  // Counter must reach NTM_DATA_SIZE itself
  localparam int unsigned step_size = $clog2(`NTM_DATA_SIZE + 1);
  localparam logic [step_size-1:0] last_step = step_size'(`NTM_DATA_SIZE);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  ntm_mod_pkg::scalar_state_t state;
  logic [step_size-1:0]       step;

  // Dividend bits leave at the top, quotient bits enter at the bottom
  logic [`NTM_DATA_SIZE-1:0]  dividend;
  logic [`NTM_DATA_SIZE-1:0]  modulus;
  logic [`NTM_DATA_SIZE-1:0]  partial;

  // One extra bit so the trial subtraction cannot wrap
  logic [`NTM_DATA_SIZE:0]    shifted;
  logic [`NTM_DATA_SIZE:0]    difference;
  logic                       quotient_bit;

  //////////////////////////////////////////////////////////////////////
  // Trial subtraction
  //////////////////////////////////////////////////////////////////////

  // Bring down next dividend bit, MSB first
  assign shifted    = {partial, dividend[`NTM_DATA_SIZE-1]};
  assign difference = shifted - {1'b0, modulus};
  // Keep the difference only when it did not go negative
  assign quotient_bit = (shifted >= {1'b0, modulus});

  // Partial remainder holds its final value once idle
  assign remainder = partial;

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_mod_pkg::idle_state;
      step  <= '0;
      ready <= 1'b0;
    end else begin
      // Ready is a single pulse
      ready <= 1'b0;
      case (state)
        ntm_mod_pkg::idle_state: begin
          if (start) begin
            step  <= '0;
            state <= ntm_mod_pkg::busy_state;
          end
        end
        ntm_mod_pkg::busy_state: begin
          // All quotient bits done, report one cycle later
          if (step == last_step) begin
            ready <= 1'b1;
            state <= ntm_mod_pkg::idle_state;
          end else begin
            step <= step + 1'b1;
          end
        end
        default: begin
          state <= ntm_mod_pkg::idle_state;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == ntm_mod_pkg::idle_state && start) begin
      // Latch pair, clear partial remainder
      dividend <= operand.data;
      modulus  <= operand.modulus;
      partial  <= '0;
    end else if (state == ntm_mod_pkg::busy_state && step != last_step) begin
      // One restoring step per cycle
      dividend <= {dividend[`NTM_DATA_SIZE-2:0], quotient_bit};
      partial  <= quotient_bit ? difference[`NTM_DATA_SIZE-1:0]
                               : shifted[`NTM_DATA_SIZE-1:0];
    end
  end

  // Controller must wait for the previous result
  a_start_only_idle : assert property (@(posedge CLK) disable iff (RST)
    start |-> state == ntm_mod_pkg::idle_state)
    else $error("scalar start while busy");

  // Result handed over in exactly one cycle
  a_ready_single : assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else $error("scalar ready held longer than one cycle");

endmodule

`default_nettype wire

/* hdl/ntm_mod_pkg.sv */
// Vector modulo shared types

`default_nettype none

`include "ntm_mod_macros.svh"

package ntm_mod_pkg;

  //////////////////////////////////////////////////////////////////////
  // Operand pair
  //////////////////////////////////////////////////////////////////////

  // One element, dividend in the upper half
  typedef struct packed {
    logic [`NTM_DATA_SIZE-1:0] data;
    logic [`NTM_DATA_SIZE-1:0] modulus;
  } mod_operand_t;

  //////////////////////////////////////////////////////////////////////
  // State encodings
  //////////////////////////////////////////////////////////////////////

  // Vector controller FSM
  typedef enum logic [1:0] {
    starter_state = 2'd0,
    input_state   = 2'd1,
    ender_state   = 2'd2
  } vector_state_t;

  // Scalar shift-subtract FSM
  typedef enum logic {
    idle_state = 1'b0,
    busy_state = 1'b1
  } scalar_state_t;

endpackage

`default_nettype wire

/* include/ntm_mod_macros.svh */
// Vector modulo width macros

`ifndef NTM_MOD_MACROS_SVH
`define NTM_MOD_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Dividend, modulus and remainder width
`define NTM_DATA_SIZE 16

//////////////////////////////////////////////////////////////////////
// Control widths
//////////////////////////////////////////////////////////////////////

// Vector length and element index width
`define NTM_CONTROL_SIZE 8

`endif
